/* bench/apb_bridge_golden.txt */
// op(0 rd,1 wr,2 rd+aw) addr id prot user needissue wdata prdata perr cen_toggle
// exp_sel_idx(8 none) exp_pwdata exp_err exp_data
0 0000001000 11 2 0 1 00000000000000000000000000000000 cafe0001 0 0 0 00000000 0 cafe0001
0 0004000004 12 3 1 1 00000000000000000000000000000000 a5a50002 0 0 1 00000000 0 a5a50002
0 0004010008 13 1 0 1 00000000000000000000000000000000 12340003 0 0 2 00000000 0 12340003
0 0004020000 14 0 0 1 00000000000000000000000000000000 00000004 0 0 3 00000000 0 00000004
0 0004024000 15 0 1 1 00000000000000000000000000000000 00000005 0 0 4 00000000 0 00000005
0 0004028000 16 1 1 1 00000000000000000000000000000000 00000006 0 0 5 00000000 0 00000006
0 000402c000 17 0 0 1 00000000000000000000000000000000 00000007 0 0 6 00000000 0 00000007
0 0004030010 18 2 0 1 00000000000000000000000000000000 76543208 0 0 7 00000000 0 76543208
1 0004000000 21 1 0 1 44444444333333332222222211111111 00000000 0 0 1 11111111 0 00000000
1 0004010004 22 3 1 1 44444444333333332222222211111111 00000000 0 0 2 22222222 0 00000000
1 0004020008 23 0 0 1 44444444333333332222222211111111 00000000 0 0 3 33333333 0 00000000
1 000403000c 24 1 1 1 44444444333333332222222211111111 00000000 0 0 7 44444444 0 00000000
0 0000002000 31 0 0 1 00000000000000000000000000000000 deadbeef 1 0 0 00000000 1 deadbeef
0 0004040000 32 0 0 1 00000000000000000000000000000000 00000000 0 0 8 00000000 1 00000000
1 0005000004 33 0 0 1 44444444333333332222222211111111 00000000 0 0 8 22222222 1 00000000
1 0004000008 34 1 0 0 44444444333333332222222211111111 00000000 0 0 8 33333333 0 00000000
2 0004030000 41 0 0 1 00000000000000000000000000000000 0badf00d 0 0 7 00000000 0 0badf00d
0 0000003004 51 3 1 1 00000000000000000000000000000000 5a5a5a5a 0 1 0 00000000 0 5a5a5a5a
1 000402c00c 52 1 0 1 44444444333333332222222211111111 00000000 0 1 6 44444444 0 00000000
0 0004024000 53 0 0 1 00000000000000000000000000000000 00000bad 1 1 4 00000000 1 00000bad

/* apb_bridge.f */
hw/apb_bridge_pkg.sv
hw/apb_req_capture.sv
hw/apb_slave_decode.sv
hw/apb_xfer_ctrl.sv
hw/apb_resp_hold.sv
hw/apb_bridge_top.sv
bench/apb_bridge_props.sv
bench/apb_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the APB bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert --top-module apb_bridge_tb \
  -f apb_bridge.f -o apb_bridge_sim > build.log 2>&1 \
  && ./obj_dir/apb_bridge_sim > sim.log 2>&1 \
  || { echo "build or run error, see build.log and sim.log"; exit 1; }

grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* bench/apb_bridge_tb.sv */
`timescale 1ns/1ps

module apb_bridge_tb
  import apb_bridge_pkg::*;
();

  logic                       apbif_clk;
  logic                       cpurst_b;
  logic                       apb_clk_en;
  logic                       arvalid;
  logic                       awvalid;
  logic                       wvalid;
  logic [pa_width-1:0]        ar_addr;
  logic [pa_width-1:0]        aw_addr;
  logic [id_width-1:0]        ar_id;
  logic [id_width-1:0]        aw_id;
  logic [prot_width-1:0]      ar_prot;
  logic [prot_width-1:0]      aw_prot;
  logic                       ar_user;
  logic                       aw_user;
  logic                       aw_needissue;
  logic [wdata_width-1:0]     wdata;
  logic                       ar_grant;
  logic                       aw_grant;
  logic                       w_grant;
  logic                       rvalid;
  logic                       bvalid;
  bridge_rsp_t                rsp_bus;
  logic                       r_grant;
  logic                       b_grant;
  logic [31:0]                paddr;
  logic [data_width-1:0]      pwdata;
  logic                       pwrite;
  logic [1:0]                 pprot;
  logic                       penable;
  apb_sel_t                   psel;
  apb_slv_rsp_t [num_slv-1:0] slv_rsp;

  // Golden table, one entry per transaction
  logic [1:0]             t_op     [64];
  logic [pa_width-1:0]    t_addr   [64];
  logic [id_width-1:0]    t_id     [64];
  logic [prot_width-1:0]  t_prot   [64];
  logic                   t_user   [64];
  logic                   t_ni     [64];
  logic [wdata_width-1:0] t_wdata  [64];
  logic [31:0]            t_prdata [64];
  logic                   t_perr   [64];
  logic                   t_cen    [64];
  logic [3:0]             t_sel    [64];
  logic [31:0]            t_pwdata [64];
  logic                   t_err    [64];
  logic [31:0]            t_data   [64];

  int          num_lines;
  logic        loaded;
  int          mismatch_cnt;
  int          other_errs;
  int          done_cnt;
  int          exp_q[$];
  integer      seed = 32'h945f_70ae;
  logic        cen_mode;
  logic [31:0] cur_prdata;
  logic        cur_perr;
  apb_sel_t    seen_sel;
  int unsigned wait_cnt [num_slv];

  apb_bridge_top dut (.*);

  initial
  begin
    apbif_clk = 1'b0;
    forever #2 apbif_clk = ~apbif_clk;
  end

  // ====================================================================
  // Compare tasks
  // ====================================================================
  task automatic check_sel(input string name, input apb_sel_t exp_v, input apb_sel_t act_v);
    if (act_v !== exp_v)
    begin
      mismatch_cnt++;
      $display("mismatch %s psel: expected %b, actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic check_data(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
    if (act_v !== exp_v)
    begin
      mismatch_cnt++;
      $display("mismatch %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_rsp(input string name, input bridge_rsp_t exp_v,
                           input bridge_rsp_t act_v);
    if (act_v !== exp_v)
    begin
      mismatch_cnt++;
      $display("mismatch %s response: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  // One-hot select for a slv_idx value, 8 and above means none
  function automatic apb_sel_t sel_from_idx(input logic [3:0] idx);
    if (idx < num_slv)
      return apb_sel_t'(1) << idx;
    return '0;
  endfunction

  task automatic load_golden();
    int                     fd;
    int                     cnt;
    string                  line;
    logic [31:0]            f_op, f_id, f_prot, f_user, f_ni, f_prdata, f_perr;
    logic [31:0]            f_cen, f_sel, f_pwdata, f_err, f_data;
    logic [63:0]            f_addr;
    logic [wdata_width-1:0] f_wdata;
    fd = $fopen("bench/apb_bridge_golden.txt", "r");
    if (fd == 0)
    begin
      other_errs++;
      $display("could not open the golden file");
      return;
    end
    while (!$feof(fd) && num_lines < 64)
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 4 || line.substr(0, 1) == "//")
        continue;
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f_op, f_addr, f_id, f_prot, f_user, f_ni, f_wdata, f_prdata,
                    f_perr, f_cen, f_sel, f_pwdata, f_err, f_data);
      if (cnt != 14)
      begin
        other_errs++;
        $display("malformed golden line: %s", line);
        continue;
      end
      t_op[num_lines]     = f_op[1:0];
      t_addr[num_lines]   = f_addr[pa_width-1:0];
      t_id[num_lines]     = f_id[id_width-1:0];
      t_prot[num_lines]   = f_prot[prot_width-1:0];
      t_user[num_lines]   = f_user[0];
      t_ni[num_lines]     = f_ni[0];
      t_wdata[num_lines]  = f_wdata;
      t_prdata[num_lines] = f_prdata;
      t_perr[num_lines]   = f_perr[0];
      t_cen[num_lines]    = f_cen[0];
      t_sel[num_lines]    = f_sel[3:0];
      t_pwdata[num_lines] = f_pwdata;
      t_err[num_lines]    = f_err[0];
      t_data[num_lines]   = f_data;
      num_lines++;
    end
    $fclose(fd);
  endtask

  // ====================================================================
  // Clock enable, peripherals and monitor
  // ====================================================================
  always @(posedge apbif_clk)
  begin
    if (cen_mode)
      apb_clk_en <= ~apb_clk_en;
    else
      apb_clk_en <= 1'b1;
  end

  // Each peripheral waits 0 to 3 enabled cycles before pready
  always @(posedge apbif_clk)
  begin
    for (int i = 0; i < num_slv; i++)
    begin
      if (psel[i])
      begin
        slv_rsp[i].prdata <= cur_prdata;
        slv_rsp[i].perr   <= cur_perr;
      end
      else
      begin
        // Unselected peripherals return junk and an error
        slv_rsp[i].prdata <= ~cur_prdata;
        slv_rsp[i].perr   <= 1'b1;
      end
      if (psel[i] && penable)
      begin
        if (wait_cnt[i] == 0)
          slv_rsp[i].pready <= 1'b1;
        else if (apb_clk_en)
          wait_cnt[i] <= wait_cnt[i] - 1;
      end
      else
      begin
        slv_rsp[i].pready <= 1'b0;
        wait_cnt[i]       <= $unsigned($random(seed)) % 4;
      end
    end
  end

  always @(posedge apbif_clk)
  begin
    if (ar_grant || aw_grant)
      seen_sel <= '0;
    else
      seen_sel <= seen_sel | psel;
    if ((ar_grant || aw_grant || w_grant) && (rvalid || bvalid))
    begin
      other_errs++;
      $display("a request was granted while a response was still held");
    end
  end

  // ====================================================================
  // Queue driver
  // ====================================================================
  task automatic drive_line(input int n);
    cur_prdata   <= t_prdata[n];
    cur_perr     <= t_perr[n];
    cen_mode     <= t_cen[n];
    ar_addr      <= t_addr[n];
    aw_addr      <= t_addr[n];
    ar_id        <= t_id[n];
    aw_id        <= t_id[n];
    ar_prot      <= t_prot[n];
    aw_prot      <= t_prot[n];
    ar_user      <= t_user[n];
    aw_user      <= t_user[n];
    aw_needissue <= t_ni[n];
    wdata        <= t_wdata[n];
    if (t_op[n] == 2'd1)
    begin
      awvalid <= 1'b1;
      do @(posedge apbif_clk); while (!aw_grant);
      awvalid <= 1'b0;
      wvalid  <= 1'b1;
      do @(posedge apbif_clk); while (!w_grant);
      wvalid <= 1'b0;
    end
    else
    begin
      // Op 2 also raises awvalid to check read priority
      arvalid <= 1'b1;
      awvalid <= (t_op[n] == 2'd2);
      do @(posedge apbif_clk); while (!ar_grant);
      if (aw_grant)
      begin
        other_errs++;
        $display("txn%0d: write granted together with a read", n);
      end
      arvalid <= 1'b0;
      awvalid <= 1'b0;
    end
    exp_q.push_back(n);
    do @(posedge apbif_clk); while (!(rvalid || bvalid));
  endtask

  // Response checker with a random grant delay
  initial
  begin : rsp_collect
    int          n;
    int          dly;
    logic        is_wr;
    bridge_rsp_t exp_rsp;
    string       name;
    wait (cpurst_b === 1'b1);
    forever
    begin
      @(posedge apbif_clk);
      if (rvalid || bvalid)
      begin
        if (exp_q.size() == 0)
        begin
          other_errs++;
          $display("response seen with no request outstanding");
          n = 0;
        end
        else
          n = exp_q.pop_front();
        name  = $sformatf("txn%0d", n);
        is_wr = (t_op[n] == 2'd1);
        if (bvalid !== is_wr)
        begin
          other_errs++;
          $display("%s: response came on the wrong channel", name);
        end
        exp_rsp.id    = t_id[n];
        exp_rsp.err   = t_err[n];
        exp_rsp.write = is_wr;
        exp_rsp.data  = t_data[n];
        check_rsp(name, exp_rsp, rsp_bus);
        check_sel(name, sel_from_idx(t_sel[n]), seen_sel);
        if (is_wr)
          check_data({name, " pwdata"}, t_pwdata[n], pwdata);
        check_data({name, " pprot"}, {30'b0, t_user[n], t_prot[n][0]}, {30'b0, pprot});
        check_data({name, " paddr"}, t_addr[n][31:0], paddr);
        check_data({name, " pwrite"}, {31'b0, is_wr}, {31'b0, pwrite});
        dly = $unsigned($random(seed)) % 4;
        repeat (dly) @(posedge apbif_clk);
        if (is_wr)
          b_grant <= 1'b1;
        else
          r_grant <= 1'b1;
        @(posedge apbif_clk);
        r_grant <= 1'b0;
        b_grant <= 1'b0;
        done_cnt++;
      end
    end
  end

  initial
  begin : watchdog
    int limit;
    wait (loaded === 1'b1);
    limit = 40;
    for (int n = 0; n < num_lines; n++)
      limit += t_cen[n] ? 80 : 40;
    repeat (limit) @(posedge apbif_clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("tests failed");
    $finish;
  end

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial
  begin
    cpurst_b     = 1'b0;
    apb_clk_en   = 1'b1;
    cen_mode     = 1'b0;
    arvalid      = 1'b0;
    awvalid      = 1'b0;
    wvalid       = 1'b0;
    ar_addr      = '0;
    aw_addr      = '0;
    ar_id        = '0;
    aw_id        = '0;
    ar_prot      = '0;
    aw_prot      = '0;
    ar_user      = 1'b0;
    aw_user      = 1'b0;
    aw_needissue = 1'b0;
    wdata        = '0;
    r_grant      = 1'b0;
    b_grant      = 1'b0;
    slv_rsp      = '0;
    seen_sel     = '0;
    cur_prdata   = '0;
    cur_perr     = 1'b0;
    num_lines    = 0;
    mismatch_cnt = 0;
    other_errs   = 0;
    done_cnt     = 0;
    loaded       = 1'b0;
    load_golden();
    if (num_lines == 0)
    begin
      other_errs++;
      $display("the golden file holds no transactions");
    end
    loaded = 1'b1;
    repeat (8) @(posedge apbif_clk);
    cpurst_b <= 1'b1;
    @(posedge apbif_clk);
    for (int n = 0; n < num_lines; n++)
      drive_line(n);
    wait (done_cnt == num_lines);
    @(posedge apbif_clk);
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_errs);
    if (mismatch_cnt == 0 && other_errs == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* bench/apb_bridge_props.sv */
`timescale 1ns/1ps

module apb_bridge_props
  import apb_bridge_pkg::*;
(
  input logic     apbif_clk,
  input logic     cpurst_b,
  input apb_sel_t psel,
  input logic     penable,
  input logic     rvalid,
  input logic     bvalid,
  input logic     ar_grant,
  input logic     aw_grant,
  input logic     w_grant
);

  // Access phase always follows a setup phase
  penable_after_psel: assert property (@(posedge apbif_clk) disable iff (!cpurst_b)
    penable |-> |$past(psel))
    else $error("penable high without psel in the previous cycle");

  psel_onehot: assert property (@(posedge apbif_clk) disable iff (!cpurst_b)
    $onehot0(psel))
    else $error("more than one psel bit high");

  rsp_channel_excl: assert property (@(posedge apbif_clk) disable iff (!cpurst_b)
    !(rvalid && bvalid))
    else $error("rvalid and bvalid high together");

  // Back-pressure from a held response
  no_grant_when_held: assert property (@(posedge apbif_clk) disable iff (!cpurst_b)
    (rvalid || bvalid) |-> !(ar_grant || aw_grant || w_grant))
    else $error("grant given while a response is held");

endmodule

bind apb_bridge_top apb_bridge_props u_props (
  .apbif_clk (apbif_clk),
  .cpurst_b  (cpurst_b),
  .psel      (psel),
  .penable   (penable),
  .rvalid    (rvalid),
  .bvalid    (bvalid),
  .ar_grant  (ar_grant),
  .aw_grant  (aw_grant),
  .w_grant   (w_grant)
);

/* hw/apb_bridge_top.sv */
`timescale 1ns/1ps

module apb_bridge_top
  import apb_bridge_pkg::*;
(
  input  logic                       apbif_clk,
  input  logic                       cpurst_b,
  input  logic                       apb_clk_en,
  // Queue request side
  input  logic                       arvalid,
  input  logic                       awvalid,
  input  logic                       wvalid,
  input  logic [pa_width-1:0]        ar_addr,
  input  logic [id_width-1:0]        ar_id,
  input  logic [prot_width-1:0]      ar_prot,
  input  logic                       ar_user,
  input  logic [pa_width-1:0]        aw_addr,
  input  logic [id_width-1:0]        aw_id,
  input  logic [prot_width-1:0]      aw_prot,
  input  logic                       aw_user,
  input  logic                       aw_needissue,
  input  logic [wdata_width-1:0]     wdata,
  output logic                       ar_grant,
  output logic                       aw_grant,
  output logic                       w_grant,
  // Queue response side
  output logic                       rvalid,
  output logic                       bvalid,
  output bridge_rsp_t                rsp_bus,
  input  logic                       r_grant,
  input  logic                       b_grant,
  // APB
  output logic [31:0]                paddr,
  output logic [data_width-1:0]      pwdata,
  output logic                       pwrite,
  output logic [1:0]                 pprot,
  output logic                       penable,
  output apb_sel_t                   psel,
  input  apb_slv_rsp_t [num_slv-1:0] slv_rsp
);

  axi_req_t              req;
  bridge_state_t         state;
  apb_sel_t              sel;
  logic                  no_target;
  logic                  cmplt;
  logic [data_width-1:0] rdata;
  logic                  perr;
  logic                  resp_busy;

  apb_req_capture u_capture (
    .apbif_clk    (apbif_clk),
    .cpurst_b     (cpurst_b),
    .apb_clk_en   (apb_clk_en),
    .arvalid      (arvalid),
    .awvalid      (awvalid),
    .wvalid       (wvalid),
    .ar_addr      (ar_addr),
    .ar_id        (ar_id),
    .ar_prot      (ar_prot),
    .ar_user      (ar_user),
    .aw_addr      (aw_addr),
    .aw_id        (aw_id),
    .aw_prot      (aw_prot),
    .aw_user      (aw_user),
    .aw_needissue (aw_needissue),
    .wdata        (wdata),
    .cmplt        (cmplt),
    .resp_busy    (resp_busy),
    .ar_grant     (ar_grant),
    .aw_grant     (aw_grant),
    .w_grant      (w_grant),
    .req          (req),
    .state        (state),
    .pwdata       (pwdata)
  );

  apb_slave_decode u_decode (
    .req       (req),
    .sel       (sel),
    .no_target (no_target)
  );

  apb_xfer_ctrl u_xfer (
    .apbif_clk  (apbif_clk),
    .cpurst_b   (cpurst_b),
    .apb_clk_en (apb_clk_en),
    .state      (state),
    .req        (req),
    .sel        (sel),
    .no_target  (no_target),
    .slv_rsp    (slv_rsp),
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .pprot      (pprot),
    .cmplt      (cmplt),
    .rdata      (rdata),
    .perr       (perr)
  );

  apb_resp_hold u_resp (
    .apbif_clk  (apbif_clk),
    .cpurst_b   (cpurst_b),
    .apb_clk_en (apb_clk_en),
    .cmplt      (cmplt),
    .rdata      (rdata),
    .perr       (perr),
    .req        (req),
    .r_grant    (r_grant),
    .b_grant    (b_grant),
    .rvalid     (rvalid),
    .bvalid     (bvalid),
    .rsp_bus    (rsp_bus),
    .resp_busy  (resp_busy)
  );

endmodule

/* hw/apb_resp_hold.sv */
`timescale 1ns/1ps

module apb_resp_hold
  import apb_bridge_pkg::*;
(
  input  logic                  apbif_clk,
  input  logic                  cpurst_b,
  input  logic                  apb_clk_en,
  input  logic                  cmplt,
  input  logic [data_width-1:0] rdata,
  input  logic                  perr,
  input  axi_req_t              req,
  input  logic                  r_grant,
  input  logic                  b_grant,
  output logic                  rvalid,
  output logic                  bvalid,
  output bridge_rsp_t           rsp_bus,
  output logic                  resp_busy
);

  logic        resp_vld;
  bridge_rsp_t rsp_q;
  logic        done;

  assign done = cmplt && apb_clk_en;

  // ====================================================================
  // Response valid
  // ====================================================================
  // The grant clears in any cycle, not only enabled ones
  always_ff @(posedge apbif_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      resp_vld <= 1'b0;
    else if (done)
      resp_vld <= 1'b1;
    else if (r_grant || b_grant)
      resp_vld <= 1'b0;
  end

  // Payload of the finished transfer
  always_ff @(posedge apbif_clk)
  begin
    if (done)
    begin
      rsp_q.id    <= req.id;
      rsp_q.err   <= perr;
      rsp_q.write <= req.write;
      // Writes return no data
      rsp_q.data  <= req.write ? '0 : rdata;
    end
  end

  // Channel steering
  assign rvalid    = resp_vld && !rsp_q.write;
  assign bvalid    = resp_vld && rsp_q.write;
  assign rsp_bus   = rsp_q;
  assign resp_busy = resp_vld;

endmodule

/* hw/apb_xfer_ctrl.sv */
`timescale 1ns/1ps

module apb_xfer_ctrl
  import apb_bridge_pkg::*;
(
  input  logic                           apbif_clk,
  input  logic                           cpurst_b,
  input  logic                           apb_clk_en,
  input  bridge_state_t                  state,
  input  axi_req_t                       req,
  input  apb_sel_t                       sel,
  input  logic                           no_target,
  input  apb_slv_rsp_t [num_slv-1:0]     slv_rsp,
  output apb_sel_t                       psel,
  output logic                           penable,
  output logic [31:0]                    paddr,
  output logic                           pwrite,
  output logic [1:0]                     pprot,
  output logic                           cmplt,
  output logic [data_width-1:0]          rdata,
  output logic                           perr
);

  apb_sel_t sel_q;
  logic     fsm_req;
  logic     fsm_pend;
  logic     issue;
  logic     sel_ready;
  logic     sel_err;

  assign fsm_req  = (state == st_req);
  assign fsm_pend = (state == st_pend);

  // ====================================================================
  // APB request side
  // ====================================================================
  assign issue = (fsm_req || fsm_pend) && req.needissue;

  assign psel   = {num_slv{issue}} & sel;
  assign paddr  = req.addr[31:0];
  assign pwrite = req.write;
  assign pprot  = req.prot;

  // Access phase only when some peripheral was actually selected
  assign penable = fsm_pend && req.needissue && !no_target;

  // Select copy used by the return merge
  always_ff @(posedge apbif_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      sel_q <= '0;
    else if (fsm_req && apb_clk_en)
      sel_q <= sel;
  end

  // ====================================================================
  // Return merge
  // ====================================================================
  always_comb
  begin
    rdata     = '0;
    sel_ready = 1'b0;
    sel_err   = 1'b0;
    for (int i = 0; i < num_slv; i++)
    begin
      rdata     = rdata | ({data_width{sel_q[i]}} & slv_rsp[i].prdata);
      sel_ready = sel_ready | (sel_q[i] & slv_rsp[i].pready);
      sel_err   = sel_err | (sel_q[i] & slv_rsp[i].perr);
    end
  end

  // Requests that never reach the bus finish straight out of pend
  assign cmplt = fsm_pend && (sel_ready || no_target || !req.needissue);

  assign perr = no_target || (req.needissue && sel_err);

endmodule

/* hw/apb_slave_decode.sv */
`timescale 1ns/1ps

module apb_slave_decode
  import apb_bridge_pkg::*;
(
  input  axi_req_t req,
  output apb_sel_t sel,
  output logic     no_target
);

  logic [region_msb-region_lsb:0] region;
  logic [core_msb-core_lsb:0]     core;
  logic                           sel_plic;
  logic                           sel_clint;
  logic                           sel_had;
  logic                           sel_l2pmp;
  logic                           sel_rmr;
  logic [num_l2pmp-1:0]           sel_core;

  assign region = req.addr[region_msb:region_lsb];
  assign core   = req.addr[core_msb:core_lsb];

  // ====================================================================
  // Region match
  // ====================================================================
  // PLIC covers the whole lower half of the window
  assign sel_plic  = (req.addr[region_msb] == plic_base);
  assign sel_clint = (region == clint_base);
  assign sel_had   = (region == had_base);
  assign sel_l2pmp = (region == l2pmp_base);
  assign sel_rmr   = (region == rmr_base);

  // One L2 PMP per core
  assign sel_core = {num_l2pmp{sel_l2pmp}} & (num_l2pmp'(1) << core);

  always_comb
  begin
    sel             = '0;
    sel[idx_plic]   = sel_plic;
    sel[idx_clint]  = sel_clint;
    sel[idx_had]    = sel_had;
    sel[idx_l2pmp0] = sel_core[0];
    sel[idx_l2pmp1] = sel_core[1];
    sel[idx_l2pmp2] = sel_core[2];
    sel[idx_l2pmp3] = sel_core[3];
    sel[idx_rmr]    = sel_rmr;
  end

  // Holes such as 0x404..0x7ff in the upper half
  assign no_target = ~|sel;

endmodule

/* hw/apb_req_capture.sv */
`timescale 1ns/1ps

module apb_req_capture
  import apb_bridge_pkg::*;
(
  input  logic                   apbif_clk,
  input  logic                   cpurst_b,
  input  logic                   apb_clk_en,
  input  logic                   arvalid,
  input  logic                   awvalid,
  input  logic                   wvalid,
  input  logic [pa_width-1:0]    ar_addr,
  input  logic [id_width-1:0]    ar_id,
  input  logic [prot_width-1:0]  ar_prot,
  input  logic                   ar_user,
  input  logic [pa_width-1:0]    aw_addr,
  input  logic [id_width-1:0]    aw_id,
  input  logic [prot_width-1:0]  aw_prot,
  input  logic                   aw_user,
  input  logic                   aw_needissue,
  input  logic [wdata_width-1:0] wdata,
  input  logic                   cmplt,
  input  logic                   resp_busy,
  output logic                   ar_grant,
  output logic                   aw_grant,
  output logic                   w_grant,
  output axi_req_t               req,
  output bridge_state_t          state,
  output logic [data_width-1:0]  pwdata
);

  bridge_state_t         state_nxt;
  logic                  fsm_idle;
  logic                  fsm_waddr;
  logic [1:0]            lane;
  logic [data_width-1:0] lane_data;

  assign fsm_idle  = (state == st_idle);
  assign fsm_waddr = (state == st_waddr);

  // ====================================================================
  // Grants
  // ====================================================================
  // Nothing is accepted while a response still waits for the queue
  assign ar_grant = arvalid && fsm_idle && apb_clk_en && !resp_busy;

  // Read wins when both address channels are valid
  assign aw_grant = awvalid && !arvalid && fsm_idle && apb_clk_en && !resp_busy;

  assign w_grant = wvalid && fsm_waddr && apb_clk_en;

  // ====================================================================
  // Bridge FSM
  // ====================================================================
  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle:
      begin
        if (ar_grant)
          state_nxt = st_req;
        else if (aw_grant)
          state_nxt = st_waddr;
      end
      st_waddr:
      begin
        if (w_grant)
          state_nxt = st_req;
      end
      // Setup phase lasts a single enabled cycle
      st_req:
      begin
        state_nxt = st_pend;
      end
      st_pend:
      begin
        if (cmplt)
          state_nxt = st_idle;
      end
      default:
      begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge apbif_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= st_idle;
    else if (apb_clk_en)
      state <= state_nxt;
  end

  // ====================================================================
  // Request register
  // ====================================================================
  // Prot keeps only the user bit and the privileged bit
  always_ff @(posedge apbif_clk)
  begin
    if (ar_grant)
    begin
      req.addr      <= ar_addr;
      req.id        <= ar_id;
      req.prot      <= {ar_user, ar_prot[0]};
      req.write     <= 1'b0;
      req.needissue <= 1'b1;
    end
    else if (aw_grant)
    begin
      req.addr      <= aw_addr;
      req.id        <= aw_id;
      req.prot      <= {aw_user, aw_prot[0]};
      req.write     <= 1'b1;
      req.needissue <= aw_needissue;
    end
  end

  // Write data lane picked by the word offset of the address
  assign lane      = req.addr[3:2];
  assign lane_data = wdata[lane*data_width +: data_width];

  always_ff @(posedge apbif_clk)
  begin
    if (w_grant)
      pwdata <= lane_data;
  end

endmodule

/* hw/apb_bridge_pkg.sv */
package apb_bridge_pkg;

  // ====================================================================
  // Widths
  // ====================================================================
  localparam int pa_width    = 40;
  localparam int id_width    = 8;
  localparam int num_slv     = 8;
  localparam int prot_width  = 3;
  localparam int data_width  = 32;
  localparam int wdata_width = 128;
  localparam int num_l2pmp   = 4;

  // ====================================================================
  // Address map
  // ====================================================================
  // Region field is paddr[26:16], PLIC only looks at bit 26
  localparam int          region_msb = 26;
  localparam int          region_lsb = 16;
  localparam logic        plic_base  = 1'b0;
  localparam logic [10:0] clint_base = 11'h400;
  localparam logic [10:0] had_base   = 11'h401;
  localparam logic [10:0] l2pmp_base = 11'h402;
  localparam logic [10:0] rmr_base   = 11'h403;

  // Core number inside the L2 PMP region
  localparam int core_msb = 15;
  localparam int core_lsb = 14;

  // Position of each peripheral in the select vector
  typedef enum logic [2:0] {
    idx_plic   = 3'd0,
    idx_clint  = 3'd1,
    idx_had    = 3'd2,
    idx_l2pmp0 = 3'd3,
    idx_l2pmp1 = 3'd4,
    idx_l2pmp2 = 3'd5,
    idx_l2pmp3 = 3'd6,
    idx_rmr    = 3'd7
  } slv_idx;

  // Bridge FSM
  typedef enum logic [1:0] {
    st_idle  = 2'b00,
    st_waddr = 2'b01,
    st_req   = 2'b10,
    st_pend  = 2'b11
  } bridge_state_t;

  // Request as latched from the queue
  typedef struct packed {
    logic [pa_width-1:0] addr;
    logic [id_width-1:0] id;
    logic [1:0]          prot;       // {user, privileged}
    logic                write;
    logic                needissue;
  } axi_req_t;

  // Return path of a single peripheral
  typedef struct packed {
    logic [data_width-1:0] prdata;
    logic                  pready;
    logic                  perr;
  } apb_slv_rsp_t;

  typedef logic [num_slv-1:0] apb_sel_t;

  // Response waiting for the queue
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic                  err;
    logic                  write;
    logic [data_width-1:0] data;
  } bridge_rsp_t;

endpackage
